// ==== Bender.yml ====
package:
  name: vector_unit

sources:
  - src/vector_unit_pkg.sv
  - src/vector_multiplier.sv
  - src/vector_accumulator.sv
  - src/vector_adder.sv
  - src/vector_unit.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/vector_unit_tb.sv

// ==== sim.f ====
+incdir+verification
src/vector_unit_pkg.sv
src/vector_multiplier.sv
src/vector_accumulator.sv
src/vector_adder.sv
src/vector_unit.sv
verification/vector_unit_tb.sv

// ==== src/vector_accumulator.sv ====
`default_nettype none

// Second stage back end for the multiply operations.
// In accumulate mode all lane products are summed together with the
// accumulator register. In saturate mode each product is brought back to
// Q15 or Q7 scale and clamped to the lane range
module vector_accumulator import vector_unit_pkg::*; (
    // Accumulator value read from the register file
    input  wire logic [31:0]  reg_accumulator_i,

    // Full products from the multiplier stage
    input  wire vmul_vector_t vmul_result_i,

    // OP_ACCUMULATE or OP_SATURATE
    input  wire logic         operation_i,

    // Lane format of the products
    input  wire esize_t       element_size_i,

    output logic [31:0]       result_o,
    output logic              overflow_flag_o
);

    // ----------------------------------------
    // Saturation logic
    // ----------------------------------------

    // Products after the arithmetic right shift, still at full width
    logic signed [2*LANE16_W-1:0] shifted16 [LANES16];
    logic signed [2*LANE8_W-1:0]  shifted8  [LANES8];

    // Clamped Q-format result and the OR of the lanes that clamped
    vector_t saturated_result;
    logic    saturated_flag;

    always_comb begin : product_shift
        // Shift both formats every cycle, only one of them is used below
        for (int i = 0; i < LANES16; i++) begin
            shifted16[i] = $signed(vmul_result_i.vect2[i]) >>> Q15_SHIFT;
        end

        for (int i = 0; i < LANES8; i++) begin
            shifted8[i] = $signed(vmul_result_i.vect4[i]) >>> Q7_SHIFT;
        end
    end : product_shift

    always_comb begin : saturation_logic
        saturated_result = '0;
        saturated_flag   = 1'b0;

        if (element_size_i == BIT16) begin
            for (int i = 0; i < LANES16; i++) begin
                // Only 0x8000 * 0x8000 lands above the upper bound
                if (shifted16[i] > LANE16_MAX) begin
                    saturated_result.vect2[i] = LANE16_MAX;
                    saturated_flag            = 1'b1;
                end else if (shifted16[i] < LANE16_MIN) begin
                    saturated_result.vect2[i] = LANE16_MIN;
                    saturated_flag            = 1'b1;
                end else begin
                    saturated_result.vect2[i] = shifted16[i][LANE16_W-1:0];
                end
            end
        end else begin
            for (int i = 0; i < LANES8; i++) begin
                // Same rule on the narrow lanes with the Q7 bounds
                if (shifted8[i] > LANE8_MAX) begin
                    saturated_result.vect4[i] = LANE8_MAX;
                    saturated_flag            = 1'b1;
                end else if (shifted8[i] < LANE8_MIN) begin
                    saturated_result.vect4[i] = LANE8_MIN;
                    saturated_flag            = 1'b1;
                end else begin
                    saturated_result.vect4[i] = shifted8[i][LANE8_W-1:0];
                end
            end
        end
    end : saturation_logic

    // ----------------------------------------
    // Accumulation logic
    // ----------------------------------------

    // Sum of all lane products, each sign extended to 32 bits
    logic signed [31:0] lane_sum;

    always_comb begin : accumulation_logic
        lane_sum = '0;

        if (element_size_i == BIT16) begin
            // The 32-bit products already fill the sum width
            for (int i = 0; i < LANES16; i++) begin
                lane_sum = lane_sum + $signed(vmul_result_i.vect2[i]);
            end
        end else begin
            // The 16-bit products are sign extended by the signed add
            for (int i = 0; i < LANES8; i++) begin
                lane_sum = lane_sum + $signed(vmul_result_i.vect4[i]);
            end
        end
    end : accumulation_logic

    // ----------------------------------------
    // Output select
    // ----------------------------------------

    always_comb begin : output_select
        case (operation_i)
            OP_SATURATE: begin
                result_o        = saturated_result;
                overflow_flag_o = saturated_flag;
            end

            default: begin
                // Accumulation wraps at 32 bits and never flags
                result_o        = reg_accumulator_i + lane_sum;
                overflow_flag_o = 1'b0;
            end
        endcase
    end : output_select

endmodule : vector_accumulator

`default_nettype wire

// ==== src/vector_adder.sv ====
`default_nettype none

// Lane-wise saturating adder and subtractor.
// Each lane is computed one bit wider than the lane itself so the true
// signed result is known, then clamped back into the lane range
module vector_adder import vector_unit_pkg::*; (
    input  wire vector_t operand_a_i,
    input  wire vector_t operand_b_i,

    // High for A minus B, low for A plus B
    input  wire logic    subtract_i,

    // Lane format of both operands
    input  wire esize_t  element_size_i,

    output vector_t      result_o,
    output logic         overflow_flag_o
);

    // ----------------------------------------
    // Widened lane arithmetic
    // ----------------------------------------

    // One extra bit holds the carry out of each lane
    logic signed [LANE16_W:0] wide16 [LANES16];
    logic signed [LANE8_W:0]  wide8  [LANES8];

    always_comb begin : lane_arith
        // Both formats are computed, the select below keeps one
        for (int i = 0; i < LANES16; i++) begin
            if (subtract_i) begin
                wide16[i] = $signed(operand_a_i.vect2[i]) - $signed(operand_b_i.vect2[i]);
            end else begin
                wide16[i] = $signed(operand_a_i.vect2[i]) + $signed(operand_b_i.vect2[i]);
            end
        end

        for (int i = 0; i < LANES8; i++) begin
            if (subtract_i) begin
                wide8[i] = $signed(operand_a_i.vect4[i]) - $signed(operand_b_i.vect4[i]);
            end else begin
                wide8[i] = $signed(operand_a_i.vect4[i]) + $signed(operand_b_i.vect4[i]);
            end
        end
    end : lane_arith

    // ----------------------------------------
    // Lane saturation
    // ----------------------------------------

    always_comb begin : lane_saturate
        result_o        = '0;
        overflow_flag_o = 1'b0;

        if (element_size_i == BIT16) begin
            for (int i = 0; i < LANES16; i++) begin
                // Positive overflow clamps high, negative clamps low
                if (wide16[i] > LANE16_MAX) begin
                    result_o.vect2[i] = LANE16_MAX;
                    overflow_flag_o   = 1'b1;
                end else if (wide16[i] < LANE16_MIN) begin
                    result_o.vect2[i] = LANE16_MIN;
                    overflow_flag_o   = 1'b1;
                end else begin
                    result_o.vect2[i] = wide16[i][LANE16_W-1:0];
                end
            end
        end else begin
            for (int i = 0; i < LANES8; i++) begin
                if (wide8[i] > LANE8_MAX) begin
                    result_o.vect4[i] = LANE8_MAX;
                    overflow_flag_o   = 1'b1;
                end else if (wide8[i] < LANE8_MIN) begin
                    result_o.vect4[i] = LANE8_MIN;
                    overflow_flag_o   = 1'b1;
                end else begin
                    result_o.vect4[i] = wide8[i][LANE8_W-1:0];
                end
            end
        end
    end : lane_saturate

endmodule : vector_adder

`default_nettype wire

// ==== src/vector_multiplier.sv ====
`default_nettype none

// First pipeline stage of the vector unit.
// Every lane of operand A is multiplied by the same lane of operand B
// and the full signed products are captured on the next clock edge
module vector_multiplier import vector_unit_pkg::*; (
    input  wire logic   clk_i,
    input  wire logic   rst_i,

    // Lane format of the operands being multiplied
    input  wire esize_t element_size_i,

    // Source operands
    input  wire vector_t operand_a_i,
    input  wire vector_t operand_b_i,

    // Registered products, one cycle behind the operands
    output vmul_vector_t product_o
);

    // ----------------------------------------
    // Lane multipliers
    // ----------------------------------------

    // Products before the pipeline register
    vmul_vector_t product_d;

    always_comb begin : lane_multiply
        // Cleared first, then each branch fills every product lane
        product_d = '0;

        if (element_size_i == BIT16) begin
            // Two 16x16 signed multiplies giving 32-bit products
            for (int i = 0; i < LANES16; i++) begin
                // Both factors are signed so the product is sign extended
                // to the full width of the product lane
                product_d.vect2[i] = $signed(operand_a_i.vect2[i])
                                   * $signed(operand_b_i.vect2[i]);
            end
        end else begin
            // Four 8x8 signed multiplies giving 16-bit products
            for (int i = 0; i < LANES8; i++) begin
                product_d.vect4[i] = $signed(operand_a_i.vect4[i])
                                   * $signed(operand_b_i.vect4[i]);
            end
        end
    end : lane_multiply

    // ----------------------------------------
    // Pipeline register
    // ----------------------------------------

    // The register loads on every cycle.
    // The stage-1 valid bit in the top tells which products belong to a
    // real operation
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            product_o <= '0;
        end else begin
            product_o <= product_d;
        end
    end

endmodule : vector_multiplier

`default_nettype wire

// ==== src/vector_unit.sv ====
`default_nettype none

// Two-stage fixed-point vector execution unit.
// Stage 1 holds the operation and operands next to the multiplier register.
// Stage 2 runs the accumulator and the adder, then registers the result
module vector_unit import vector_unit_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        rst_i,

    // One operation is accepted on every cycle this strobe is high
    input  wire logic        valid_i,
    input  wire vop_t        op_i,
    input  wire esize_t      element_size_i,
    input  wire vector_t     operand_a_i,
    input  wire vector_t     operand_b_i,
    input  wire logic [31:0] reg_accumulator_i,

    // Result strobe, two cycles after the matching valid_i
    output logic             valid_o,
    output logic [31:0]      result_o,
    output logic             overflow_flag_o
);

    // ----------------------------------------
    // Stage 1 registers
    // ----------------------------------------

    logic        valid_s1;
    vop_t        op_s1;
    esize_t      element_size_s1;
    vector_t     operand_a_s1;
    vector_t     operand_b_s1;
    logic [31:0] accumulator_s1;

    // Stage 1 valid bit, one cycle behind the input strobe
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= valid_i;
        end
    end

    // Payload loads only with a strobe, idle cycles leave it alone
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            op_s1           <= op_i;
            element_size_s1 <= element_size_i;
            operand_a_s1    <= operand_a_i;
            operand_b_s1    <= operand_b_i;
            accumulator_s1  <= reg_accumulator_i;
        end
    end

    // Products land in the same edge as the stage 1 registers above
    vmul_vector_t product_s1;

    vector_multiplier u_multiplier (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .element_size_i ( element_size_i ),
        .operand_a_i    ( operand_a_i    ),
        .operand_b_i    ( operand_b_i    ),
        .product_o      ( product_s1     )
    );

    // ----------------------------------------
    // Stage 2 datapath
    // ----------------------------------------

    // VMULQ saturates, VMAC accumulates. The adder ops never read this
    logic        accumulator_mode;
    logic        subtract;
    logic [31:0] accumulator_result;
    logic        accumulator_flag;
    vector_t     adder_result;
    logic        adder_flag;

    assign accumulator_mode = (op_s1 == VMULQ) ? OP_SATURATE : OP_ACCUMULATE;
    assign subtract         = (op_s1 == VSUB);

    vector_accumulator u_accumulator (
        .reg_accumulator_i ( accumulator_s1     ),
        .vmul_result_i     ( product_s1         ),
        .operation_i       ( accumulator_mode   ),
        .element_size_i    ( element_size_s1    ),
        .result_o          ( accumulator_result ),
        .overflow_flag_o   ( accumulator_flag   )
    );

    vector_adder u_adder (
        .operand_a_i     ( operand_a_s1    ),
        .operand_b_i     ( operand_b_s1    ),
        .subtract_i      ( subtract        ),
        .element_size_i  ( element_size_s1 ),
        .result_o        ( adder_result    ),
        .overflow_flag_o ( adder_flag      )
    );

    // ----------------------------------------
    // Result select and output register
    // ----------------------------------------

    logic [31:0] select_result;
    logic        select_flag;

    always_comb begin : result_select
        case (op_s1)
            VADD, VSUB: begin
                select_result = adder_result;
                select_flag   = adder_flag;
            end

            default: begin
                select_result = accumulator_result;
                select_flag   = accumulator_flag;
            end
        endcase
    end : result_select

    // Result and flag hold their last value between strobes
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o         <= 1'b0;
            result_o        <= '0;
            overflow_flag_o <= 1'b0;
        end else begin
            valid_o <= valid_s1;

            if (valid_s1) begin
                result_o        <= select_result;
                overflow_flag_o <= select_flag;
            end
        end
    end

endmodule : vector_unit

`default_nettype wire

// ==== src/vector_unit_pkg.sv ====
`default_nettype none

package vector_unit_pkg;

    // ----------------------------------------
    // Lane geometry
    // ----------------------------------------

    // Width of one lane in each element format
    localparam int LANE16_W = 16;
    localparam int LANE8_W  = 8;

    // Number of lanes packed into a 32-bit operand
    localparam int LANES16 = 2;
    localparam int LANES8  = 4;

    // Right shifts that bring a full product back to Q15 or Q7 scale
    localparam int Q15_SHIFT = 15;
    localparam int Q7_SHIFT  = 7;

    // Saturation bounds of a signed lane
    localparam logic signed [LANE16_W-1:0] LANE16_MAX = 16'sh7FFF;
    localparam logic signed [LANE16_W-1:0] LANE16_MIN = 16'sh8000;
    localparam logic signed [LANE8_W-1:0]  LANE8_MAX  = 8'sh7F;
    localparam logic signed [LANE8_W-1:0]  LANE8_MIN  = 8'sh80;

    // Modes of the accumulator block, picked by the top from the operation
    localparam logic OP_ACCUMULATE = 1'b0;
    localparam logic OP_SATURATE   = 1'b1;

    // ----------------------------------------
    // Encodings
    // ----------------------------------------

    // BIT16 splits a word in two lanes, BIT8 in four
    typedef enum logic {
        BIT16 = 1'b0,
        BIT8  = 1'b1
    } esize_t;

    // Operation code carried down the pipeline
    typedef enum logic [1:0] {
        VMAC  = 2'b00,
        VMULQ = 2'b01,
        VADD  = 2'b10,
        VSUB  = 2'b11
    } vop_t;

    // ----------------------------------------
    // Operand and product words
    // ----------------------------------------

    // One 32-bit operand seen as two or four lanes, lane 0 in the low bits
    typedef union packed {
        logic [LANES16-1:0][LANE16_W-1:0] vect2;
        logic [LANES8-1:0][LANE8_W-1:0]   vect4;
    } vector_t;

    // Full-width products, each twice as wide as its source lane
    typedef union packed {
        logic [LANES16-1:0][2*LANE16_W-1:0] vect2;
        logic [LANES8-1:0][2*LANE8_W-1:0]   vect4;
    } vmul_vector_t;

endpackage : vector_unit_pkg

`default_nettype wire

// ==== verification/vector_unit_model.svh ====
`ifndef VECTOR_UNIT_MODEL_SVH
`define VECTOR_UNIT_MODEL_SVH

// Reference model of the vector unit, built on plain integer arithmetic.
// Lanes are pulled out of a word by shifting, so any lane width works

// Signed value of lane i when the word is cut into lanes of the given width
function automatic longint lane_of(logic [31:0] word, int width, int i);
    longint raw;
    raw = (longint'(word) >> (width * i)) & ((longint'(1) << width) - 1);
    // Top bit of the lane set means a negative number
    if (raw >= (longint'(1) << (width - 1))) begin
        raw = raw - (longint'(1) << width);
    end
    return raw;
endfunction

// Pulls a value into the signed range of a lane and notes when it had to
function automatic longint clamp_lane(longint value, int width, inout logic clamped);
    longint hi;
    longint lo;
    hi = (longint'(1) << (width - 1)) - 1;
    lo = -(longint'(1) << (width - 1));
    if (value > hi) begin
        clamped = 1'b1;
        return hi;
    end else if (value < lo) begin
        clamped = 1'b1;
        return lo;
    end
    return value;
endfunction

// Expected {flag, result} of one operation on the given operands
function automatic logic [32:0] expected_outcome(vop_t op_code, esize_t size,
        logic [31:0] a, logic [31:0] b, logic [31:0] acc);
    int          width;
    int          shift;
    longint      lane;
    longint      total;
    logic        flag;
    logic [31:0] word;
    width = (size == BIT16) ? 16 : 8;
    shift = (size == BIT16) ? Q15_SHIFT : Q7_SHIFT;
    total = longint'(acc);
    flag  = 1'b0;
    word  = '0;
    for (int i = 0; i < 32 / width; i++) begin
        lane = 0;
        case (op_code)
            VMAC:  total = total + lane_of(a, width, i) * lane_of(b, width, i);
            VMULQ: lane = clamp_lane((lane_of(a, width, i) * lane_of(b, width, i)) >>> shift,
                                     width, flag);
            VADD:  lane = clamp_lane(lane_of(a, width, i) + lane_of(b, width, i), width, flag);
            VSUB:  lane = clamp_lane(lane_of(a, width, i) - lane_of(b, width, i), width, flag);
        endcase
        word = word | 32'((lane & ((longint'(1) << width) - 1)) << (width * i));
    end
    // Accumulation wraps modulo 2^32 and never raises the flag
    if (op_code == VMAC) begin
        word = total[31:0];
        flag = 1'b0;
    end
    return {flag, word};
endfunction

`endif

// ==== verification/vector_unit_tb.sv ====
`default_nettype none

// Testbench for the two-stage vector unit.
// Each issued operation queues its expected outcome and the output checker
// pops one entry on every cycle that valid_o is high
module vector_unit_tb import vector_unit_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_OPS   = 16;
    localparam int MIXED_OPS    = 24;
    // Three random runs, six directed corner cases and the mixed burst
    localparam int TOTAL_OPS    = 3 * RANDOM_OPS + 6 + MIXED_OPS;
    localparam int LIMIT_CYCLES = RESET_CYCLES + 20 * TOTAL_OPS;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    vop_t        op;
    esize_t      esize;
    vector_t     operand_a;
    vector_t     operand_b;
    logic [31:0] accumulator;
    logic        out_valid;
    logic [31:0] result;
    logic        overflow_flag;

    // Expected {flag, result} of every operation still in the pipeline
    logic [32:0] expected_q [$];
    int          seed    = 11;
    int          issued  = 0;
    int          checked = 0;
    int          errors  = 0;

    `include "vector_unit_model.svh"

    vector_unit uut (
        .clk_i             ( clk           ),
        .rst_i             ( rst           ),
        .valid_i           ( in_valid      ),
        .op_i              ( op            ),
        .element_size_i    ( esize         ),
        .operand_a_i       ( operand_a     ),
        .operand_b_i       ( operand_b     ),
        .reg_accumulator_i ( accumulator   ),
        .valid_o           ( out_valid     ),
        .result_o          ( result        ),
        .overflow_flag_o   ( overflow_flag )
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------

    // Presents one operation on the next rising edge and queues its outcome
    task automatic issue(input vop_t op_code, input esize_t size, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] acc);
        @(posedge clk);
        in_valid    <= 1'b1;
        op          <= op_code;
        esize       <= size;
        operand_a   <= a;
        operand_b   <= b;
        accumulator <= acc;
        expected_q.push_back(expected_outcome(op_code, size, a, b, acc));
        issued++;
    endtask

    task automatic issue_random(input vop_t op_code, input esize_t size);
        issue(op_code, size, $random(seed), $random(seed), $random(seed));
    endtask

    // Drops the strobe and waits until every queued result came back
    task automatic drain(input string phase);
        @(posedge clk);
        in_valid <= 1'b0;
        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        $display("%s: finished, %0d issued, %0d checked, %0d errors",
                 phase, issued, checked, errors);
    endtask

    // ----------------------------------------
    // Checkers
    // ----------------------------------------

    // Reads at the edge see the outputs registered on the previous edge
    always @(posedge clk) begin : output_check
        logic [32:0] expected;
        if (!rst && out_valid) begin
            if (expected_q.size() == 0) begin
                errors++;
                $display("valid_o was raised with no operation waiting for it");
            end else begin
                expected = expected_q.pop_front();
                checked++;
                assert (result == expected[31:0]) else begin
                    errors++;
                    $display("mismatch result_o: got %h, expected %h", result, expected[31:0]);
                end
                assert (overflow_flag == expected[32]) else begin
                    errors++;
                    $display("mismatch overflow_flag_o: got %h, expected %h",
                             overflow_flag, expected[32]);
                end
            end
        end
    end

    // A result strobe exactly two cycles after each input strobe, and no other
    latency_check: assert property (@(posedge clk) disable iff (rst)
                                    out_valid == $past(in_valid, 2))
        else begin
            errors++;
            $display("valid_o did not follow valid_i by exactly two cycles");
        end

    initial begin : watchdog
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin : stimulus
        rst         = 1'b1;
        in_valid    = 1'b0;
        op          = VMAC;
        esize       = BIT16;
        operand_a   = '0;
        operand_b   = '0;
        accumulator = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // Outputs stay cleared through the idle cycles before the first strobe
        repeat (4) begin
            @(posedge clk);
            assert (!out_valid) else begin
                errors++;
                $display("mismatch valid_o: got %h, expected %h", out_valid, 1'b0);
            end
            assert (result == '0) else begin
                errors++;
                $display("mismatch result_o: got %h, expected %h", result, 32'h0);
            end
            assert (!overflow_flag) else begin
                errors++;
                $display("mismatch overflow_flag_o: got %h, expected %h",
                         overflow_flag, 1'b0);
            end
        end
        $display("reset: finished, %0d errors", errors);

        for (int i = 0; i < RANDOM_OPS; i++) begin
            issue_random(VMAC, esize_t'(1'(i)));
        end
        drain("multiply-accumulate");

        // Most negative times most negative is the only product that saturates
        issue(VMULQ, BIT16, 32'h8000_8000, 32'h8000_8000, '0);
        issue(VMULQ, BIT8, 32'h8080_8080, 32'h8080_8080, '0);
        for (int i = 0; i < RANDOM_OPS; i++) begin
            issue_random(VMULQ, esize_t'(1'(i)));
        end
        drain("q-format multiply");

        // Upward and downward overflow in every lane of both formats
        issue(VADD, BIT16, 32'h7FFF_7FFF, 32'h0001_0001, '0);
        issue(VSUB, BIT16, 32'h8000_8000, 32'h0001_0001, '0);
        issue(VADD, BIT8, 32'h7F7F_7F7F, 32'h0101_0101, '0);
        issue(VSUB, BIT8, 32'h8080_8080, 32'h0101_0101, '0);
        for (int i = 0; i < RANDOM_OPS; i++) begin
            issue_random(i % 2 ? VSUB : VADD, esize_t'(1'(i / 2)));
        end
        drain("saturating add and subtract");

        for (int i = 0; i < MIXED_OPS; i++) begin
            issue_random(vop_t'(2'($random(seed))), esize_t'(1'($random(seed))));
            // Now and then an idle cycle splits the burst
            if (($random(seed) & 3) == 0) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
        end
        drain("back-to-back issue");

        $display("summary: %0d issued, %0d checked, %0d errors", issued, checked, errors);
        if (errors == 0 && checked == issued) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : vector_unit_tb

`default_nettype wire
